//--- include/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath width
`define RV_XLEN  32

// architectural registers, x0 included
`define RV_NREGS 32

`endif

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,   // no data memory, retires illegal
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,   // no data memory, retires illegal
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } op_e;

    typedef enum logic [3:0] {
        ALU_OP_ADD,
        ALU_OP_SUB,
        ALU_OP_AND,
        ALU_OP_OR,
        ALU_OP_XOR,
        ALU_OP_SLL,
        ALU_OP_SRL,
        ALU_OP_SRA,
        ALU_OP_SLT,
        ALU_OP_SLTU,
        ALU_OP_NONE
    } alu_op_e;

    // operand a or b of the ALU
    typedef enum logic [1:0] {
        ALU_SRC_REG,
        ALU_SRC_IMM,
        ALU_SRC_PC,
        ALU_SRC_NONE
    } alu_src_e;

    typedef enum logic [1:0] {
        RES_SRC_ALU,
        RES_SRC_IMM,
        RES_SRC_PC_PLUS_4,
        RES_SRC_NONE
    } res_src_e;

    typedef enum logic [2:0] {
        IMM_SRC_I,
        IMM_SRC_I_SHIFT,   // shamt only
        IMM_SRC_B,
        IMM_SRC_J,
        IMM_SRC_U,
        IMM_SRC_NONE
    } imm_src_e;

    typedef enum logic [1:0] {
        PC_SRC_PLUS_4,
        PC_SRC_PLUS_OFF,
        PC_SRC_REG_PLUS_OFF,
        PC_SRC_NONE
    } pc_src_e;

endpackage

//--- design/rv_pipe_pkg.sv
`include "rv_core_defs.svh"

package rv_pipe_pkg;

    typedef struct packed {
        logic                 reg_we;
        rv_isa_pkg::alu_src_e alu_src_a;
        rv_isa_pkg::alu_src_e alu_src_b;
        rv_isa_pkg::res_src_e result_src;
        rv_isa_pkg::pc_src_e  pc_src;
        rv_isa_pkg::imm_src_e imm_src;
        rv_isa_pkg::alu_op_e  alu_ctrl;
        logic [2:0]           br_funct3;   // branch condition
        logic                 illegal;
    } ctrl_t;

    // decode -> execute
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        ctrl_t               ctrl;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] op_a;
        logic [`RV_XLEN-1:0] op_b;
        logic [`RV_XLEN-1:0] rs2_val;
        logic [`RV_XLEN-1:0] imm;
    } dec_payload_t;

    // execute -> write-back
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic                reg_we;
        logic [`RV_XLEN-1:0] result;
        logic [`RV_XLEN-1:0] next_pc;
        logic                illegal;
    } ex_payload_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } fwd_t;

    // same layout as ex_payload_t
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic                reg_we;
        logic [`RV_XLEN-1:0] result;
        logic [`RV_XLEN-1:0] next_pc;
        logic                illegal;
    } retire_t;

endpackage

//--- design/rv_controller.sv
`timescale 1ns/1ps

module rv_controller (
    input  logic [31:0]        instr,
    output rv_pipe_pkg::ctrl_t ctrl
);
    import rv_isa_pkg::*;

    op_e        op;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    alu_arith;   // OP / OP-IMM operation
    imm_src_e   imm_i;

    assign op     = op_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // slli/srli/srai take a shamt, the rest a signed 12-bit value
    assign imm_i = (funct3[1:0] == 2'b01) ? IMM_SRC_I_SHIFT : IMM_SRC_I;

    always_comb begin
        case (funct3)
            3'b000:  alu_arith = (op == OP_OP && funct7[5]) ? ALU_OP_SUB : ALU_OP_ADD;
            3'b001:  alu_arith = ALU_OP_SLL;
            3'b010:  alu_arith = ALU_OP_SLT;
            3'b011:  alu_arith = ALU_OP_SLTU;
            3'b100:  alu_arith = ALU_OP_XOR;
            3'b101:  alu_arith = funct7[5] ? ALU_OP_SRA : ALU_OP_SRL;
            3'b110:  alu_arith = ALU_OP_OR;
            default: alu_arith = ALU_OP_AND;
        endcase
    end

    always_comb begin
        ctrl.reg_we     = 1'b1;
        ctrl.alu_src_a  = ALU_SRC_NONE;
        ctrl.alu_src_b  = ALU_SRC_NONE;
        ctrl.result_src = RES_SRC_ALU;
        ctrl.pc_src     = PC_SRC_PLUS_4;
        ctrl.imm_src    = IMM_SRC_NONE;
        ctrl.alu_ctrl   = ALU_OP_NONE;
        ctrl.br_funct3  = funct3;
        ctrl.illegal    = 1'b0;
        case (op)
            OP_OP: begin
                ctrl.alu_src_a = ALU_SRC_REG;
                ctrl.alu_src_b = ALU_SRC_REG;
                ctrl.alu_ctrl  = alu_arith;
            end
            OP_IMM: begin
                ctrl.alu_src_a = ALU_SRC_REG;
                ctrl.alu_src_b = ALU_SRC_IMM;
                ctrl.imm_src   = imm_i;
                ctrl.alu_ctrl  = alu_arith;
            end
            OP_LUI: begin
                ctrl.result_src = RES_SRC_IMM;
                ctrl.imm_src    = IMM_SRC_U;
            end
            OP_AUIPC: begin
                ctrl.alu_src_a = ALU_SRC_PC;
                ctrl.alu_src_b = ALU_SRC_IMM;
                ctrl.imm_src   = IMM_SRC_U;
                ctrl.alu_ctrl  = ALU_OP_ADD;
            end
            OP_JAL: begin
                ctrl.result_src = RES_SRC_PC_PLUS_4;
                ctrl.pc_src     = PC_SRC_PLUS_OFF;
                ctrl.imm_src    = IMM_SRC_J;
            end
            OP_JALR: begin
                ctrl.alu_src_a  = ALU_SRC_REG;   // target = rs1 + imm through the adder
                ctrl.alu_src_b  = ALU_SRC_IMM;
                ctrl.result_src = RES_SRC_PC_PLUS_4;
                ctrl.pc_src     = PC_SRC_REG_PLUS_OFF;
                ctrl.imm_src    = IMM_SRC_I;
                ctrl.alu_ctrl   = ALU_OP_ADD;
            end
            OP_BRANCH: begin
                ctrl.reg_we     = 1'b0;
                ctrl.alu_src_a  = ALU_SRC_REG;
                ctrl.result_src = RES_SRC_NONE;
                ctrl.pc_src     = PC_SRC_PLUS_OFF;
                ctrl.imm_src    = IMM_SRC_B;
                ctrl.alu_ctrl   = ALU_OP_SUB;   // flags of rs1 - rs2
            end
            default: begin   // loads, stores and anything unknown
                ctrl.reg_we     = 1'b0;
                ctrl.result_src = RES_SRC_NONE;
                ctrl.pc_src     = PC_SRC_NONE;
                ctrl.illegal    = 1'b1;
            end
        endcase
    end

    always_comb begin
        a_illegal_no_we: assert #0 (!(ctrl.illegal && ctrl.reg_we))
            else $error("control word flagged illegal still writes a register");
    end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2,
    input  logic                we,
    input  logic [4:0]          waddr,
    input  logic [`RV_XLEN-1:0] wdata
);
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n)
            regs[0] <= '0;   // x0 only ever holds its reset value
        else if (we && waddr != 5'd0)
            regs[waddr] <= wdata;
    end

    always_comb begin
        if (we && waddr != 5'd0 && waddr == rs1)
            rdata1 = wdata;   // write-through
        else
            rdata1 = regs[rs1];
    end

    always_comb begin
        if (we && waddr != 5'd0 && waddr == rs2)
            rdata2 = wdata;
        else
            rdata2 = regs[rs2];
    end

    // writes aimed at x0 never show on either read port
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 != 5'd0 || rdata1 == '0) && (rs2 != 5'd0 || rdata2 == '0));

endmodule

//--- design/rv_pipe_reg.sv
`timescale 1ns/1ps

module rv_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    assign in_ready = !out_valid || out_ready;   // empty or draining

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            out_data <= in_data;
    end

    // stalled entry holds its value until taken
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- design/rv_decode_stage.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_decode_stage (
    input  logic [31:0]               instr,
    input  logic [`RV_XLEN-1:0]       pc,
    output logic [4:0]                rs1_idx,
    output logic [4:0]                rs2_idx,
    input  logic [`RV_XLEN-1:0]       rdata1,
    input  logic [`RV_XLEN-1:0]       rdata2,
    input  rv_pipe_pkg::fwd_t         ex_fwd,
    input  rv_pipe_pkg::fwd_t         wb_fwd,
    output rv_pipe_pkg::dec_payload_t payload
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;

    // youngest producer first, x0 never forwarded
    function automatic logic [`RV_XLEN-1:0] fwd_pick(
        input logic [4:0]          idx,
        input logic [`RV_XLEN-1:0] rf_val,
        input fwd_t                ex,
        input fwd_t                wb
    );
        if (idx == 5'd0)
            return '0;
        if (ex.valid && ex.rd == idx)
            return ex.data;
        if (wb.valid && wb.rd == idx)
            return wb.data;
        return rf_val;
    endfunction

    rv_controller u_ctrl (
        .instr (instr),
        .ctrl  (ctrl)
    );

    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rs1_val = fwd_pick(rs1_idx, rdata1, ex_fwd, wb_fwd);
    assign rs2_val = fwd_pick(rs2_idx, rdata2, ex_fwd, wb_fwd);

    always_comb begin
        case (ctrl.imm_src)
            IMM_SRC_I:       imm = {{20{instr[31]}}, instr[31:20]};
            IMM_SRC_I_SHIFT: imm = {27'b0, instr[24:20]};
            IMM_SRC_B:       imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_SRC_J:       imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            IMM_SRC_U:       imm = {instr[31:12], 12'b0};
            default:         imm = '0;
        endcase
    end

    always_comb begin
        payload.pc      = pc;
        payload.ctrl    = ctrl;
        payload.rd      = instr[11:7];
        payload.rs2_val = rs2_val;
        payload.imm     = imm;
        case (ctrl.alu_src_a)
            ALU_SRC_REG: payload.op_a = rs1_val;
            ALU_SRC_PC:  payload.op_a = pc;   // auipc
            default:     payload.op_a = '0;
        endcase
        case (ctrl.alu_src_b)
            ALU_SRC_REG: payload.op_b = rs2_val;
            ALU_SRC_IMM: payload.op_b = imm;
            default:     payload.op_b = '0;
        endcase
    end

endmodule

//--- design/rv_execute_stage.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_execute_stage (
    input  rv_pipe_pkg::dec_payload_t payload,
    input  logic                      valid,
    output rv_pipe_pkg::fwd_t         ex_fwd,
    output rv_pipe_pkg::ex_payload_t  result
);
    import rv_isa_pkg::*;

    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] b_eff;
    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] target;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] res_val;
    logic                is_branch;
    logic                sub_op;
    logic                negative, zero, carry, overflow;
    logic                taken;

    assign is_branch = (payload.ctrl.imm_src == IMM_SRC_B);
    assign alu_a     = payload.op_a;
    assign alu_b     = is_branch ? payload.rs2_val : payload.op_b;   // compare rs1 with rs2

    // shared adder, subtract as a + ~b + 1
    assign sub_op       = (payload.ctrl.alu_ctrl == ALU_OP_SUB);
    assign b_eff        = sub_op ? ~alu_b : alu_b;
    assign {carry, sum} = {1'b0, alu_a} + {1'b0, b_eff} + {{`RV_XLEN{1'b0}}, sub_op};
    assign overflow     = (alu_a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) &&
                          (sum[`RV_XLEN-1] != alu_a[`RV_XLEN-1]);

    always_comb begin
        case (payload.ctrl.alu_ctrl)
            ALU_OP_ADD, ALU_OP_SUB: alu_y = sum;
            ALU_OP_AND:  alu_y = alu_a & alu_b;
            ALU_OP_OR:   alu_y = alu_a | alu_b;
            ALU_OP_XOR:  alu_y = alu_a ^ alu_b;
            ALU_OP_SLL:  alu_y = alu_a << alu_b[4:0];
            ALU_OP_SRL:  alu_y = alu_a >> alu_b[4:0];
            ALU_OP_SRA:  alu_y = $signed(alu_a) >>> alu_b[4:0];
            ALU_OP_SLT:  alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_OP_SLTU: alu_y = {{(`RV_XLEN-1){1'b0}}, alu_a < alu_b};
            default:     alu_y = '0;
        endcase
    end

    assign negative = alu_y[`RV_XLEN-1];
    assign zero     = (alu_y == '0);

    always_comb begin
        case (payload.ctrl.br_funct3)
            3'b000:  taken = zero;                    // beq
            3'b001:  taken = !zero;                   // bne
            3'b100:  taken = negative ^ overflow;     // blt
            3'b101:  taken = !(negative ^ overflow);  // bge
            3'b110:  taken = !carry;                  // bltu, borrow
            3'b111:  taken = carry;                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = payload.pc + `RV_XLEN'd4;
    assign target   = payload.pc + payload.imm;

    always_comb begin
        case (payload.ctrl.pc_src)
            PC_SRC_PLUS_OFF:     next_pc = (!is_branch || taken) ? target : pc_plus4;
            PC_SRC_REG_PLUS_OFF: next_pc = {sum[`RV_XLEN-1:1], 1'b0};   // jalr drops bit 0
            default:             next_pc = pc_plus4;
        endcase
        case (payload.ctrl.result_src)
            RES_SRC_ALU:       res_val = alu_y;
            RES_SRC_IMM:       res_val = payload.imm;
            RES_SRC_PC_PLUS_4: res_val = pc_plus4;
            default:           res_val = '0;
        endcase
    end

    assign result.pc      = payload.pc;
    assign result.rd      = payload.rd;
    assign result.reg_we  = payload.ctrl.reg_we;
    assign result.result  = res_val;
    assign result.next_pc = next_pc;
    assign result.illegal = payload.ctrl.illegal;

    assign ex_fwd.valid = valid && payload.ctrl.reg_we && (payload.rd != 5'd0);
    assign ex_fwd.rd    = payload.rd;
    assign ex_fwd.data  = res_val;

endmodule

//--- design/rv_exec_core.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_exec_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [31:0]          in_instr,
    input  logic [`RV_XLEN-1:0]  in_pc,
    output logic                 retire_valid,
    input  logic                 retire_ready,
    output rv_pipe_pkg::retire_t retire
);
    import rv_pipe_pkg::*;

    dec_payload_t        dec_d;
    dec_payload_t        dec_q;
    logic                dec_valid;
    logic                dec_ready;
    ex_payload_t         ex_d;
    ex_payload_t         ex_q;
    fwd_t                ex_fwd;
    fwd_t                wb_fwd;
    logic [4:0]          rs1_idx;
    logic [4:0]          rs2_idx;
    logic [`RV_XLEN-1:0] rdata1;
    logic [`RV_XLEN-1:0] rdata2;

    rv_decode_stage u_decode (
        .instr   (in_instr),
        .pc      (in_pc),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .ex_fwd  (ex_fwd),
        .wb_fwd  (wb_fwd),
        .payload (dec_d)
    );

    rv_pipe_reg #(.payload_t(dec_payload_t)) u_dec_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (dec_d),
        .out_valid (dec_valid),
        .out_ready (dec_ready),
        .out_data  (dec_q)
    );

    rv_execute_stage u_execute (
        .payload (dec_q),
        .valid   (dec_valid),
        .ex_fwd  (ex_fwd),
        .result  (ex_d)
    );

    rv_pipe_reg #(.payload_t(ex_payload_t)) u_ret_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dec_valid),
        .in_ready  (dec_ready),
        .in_data   (ex_d),
        .out_valid (retire_valid),
        .out_ready (retire_ready),
        .out_data  (ex_q)
    );

    // write-back happens on the retire handshake
    rv_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (rs1_idx),
        .rs2    (rs2_idx),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (retire_valid && retire_ready && ex_q.reg_we),
        .waddr  (ex_q.rd),
        .wdata  (ex_q.result)
    );

    assign wb_fwd.valid = retire_valid && ex_q.reg_we && (ex_q.rd != 5'd0);
    assign wb_fwd.rd    = ex_q.rd;
    assign wb_fwd.data  = ex_q.result;

    assign retire = retire_t'(ex_q);   // identical field layout

endmodule

//--- include/rv_tb_ref.svh
`ifndef RV_TB_REF_SVH
`define RV_TB_REF_SVH

`include "rv_core_defs.svh"

// RV32I integer operation, alt selects sub and sra
function automatic logic [`RV_XLEN-1:0] alu_ref(
    input logic [2:0]          f3,
    input logic                alt,
    input logic [`RV_XLEN-1:0] a,
    input logic [`RV_XLEN-1:0] b
);
    logic [`RV_XLEN-1:0] y;
    y = '0;
    case (f3)
        3'd0: y = alt ? a - b : a + b;
        3'd1: y = a << b[4:0];
        3'd2: y[0] = $signed(a) < $signed(b);
        3'd3: y[0] = a < b;
        3'd4: y = a ^ b;
        3'd5: begin
            if (alt)
                y = $signed(a) >>> b[4:0];
            else
                y = a >> b[4:0];
        end
        3'd6: y = a | b;
        default: y = a & b;
    endcase
    return y;
endfunction

// expected retire record; the shadow registers advance as an in-order core would
function automatic rv_pipe_pkg::retire_t ref_retire(
    input logic [31:0]                        instr,
    input logic [`RV_XLEN-1:0]                pc,
    inout logic [`RV_NREGS-1:0][`RV_XLEN-1:0] regs
);
    rv_pipe_pkg::retire_t r;
    logic [`RV_XLEN-1:0]  a;
    logic [`RV_XLEN-1:0]  b;
    logic [`RV_XLEN-1:0]  imm_i;
    logic [`RV_XLEN-1:0]  imm_b;
    logic [`RV_XLEN-1:0]  imm_j;
    logic [`RV_XLEN-1:0]  imm_u;
    logic                 taken;
    a     = regs[instr[19:15]];
    b     = regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    imm_u = {instr[31:12], 12'd0};
    case (instr[14:12])
        3'd0:    taken = (a == b);
        3'd1:    taken = (a != b);
        3'd4:    taken = $signed(a) < $signed(b);
        3'd5:    taken = $signed(a) >= $signed(b);
        3'd6:    taken = a < b;
        3'd7:    taken = a >= b;
        default: taken = 1'b0;
    endcase
    r         = '0;
    r.pc      = pc;
    r.rd      = instr[11:7];
    r.reg_we  = 1'b1;
    r.next_pc = pc + 4;
    case (instr[6:0])
        7'b0110011: r.result = alu_ref(instr[14:12], instr[30], a, b);
        7'b0010011: r.result = alu_ref(instr[14:12], instr[14:12] == 3'd5 && instr[30],
                                       a, imm_i);   // no subi, srai only
        7'b0110111: r.result = imm_u;        // lui
        7'b0010111: r.result = pc + imm_u;   // auipc
        7'b1101111: begin   // jal
            r.result  = pc + 4;
            r.next_pc = pc + imm_j;
        end
        7'b1100111: begin   // jalr
            r.result     = pc + 4;
            r.next_pc    = a + imm_i;
            r.next_pc[0] = 1'b0;
        end
        7'b1100011: begin
            r.reg_we = 1'b0;
            if (taken)
                r.next_pc = pc + imm_b;
        end
        default: begin   // loads, stores, unknown
            r.reg_we  = 1'b0;
            r.illegal = 1'b1;
        end
    endcase
    if (r.reg_we && r.rd != 5'd0)
        regs[r.rd] = r.result;
    return r;
endfunction

`endif

//--- bench/rv_exec_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_exec_core_tb;
    import rv_pipe_pkg::*;

    localparam int N_ALU       = 200;
    localparam int N_CHAIN     = 150;
    localparam int N_FLOW      = 150;
    localparam int N_BP        = 200;
    localparam int N_ILL       = 40;
    localparam int N_FIXED     = 66 + 31 + 32;   // directed setup and read-back words
    localparam int N_TOTAL     = N_ALU + N_CHAIN + N_FLOW + N_BP + N_ILL + N_FIXED;
    localparam int CYCLE_LIMIT = N_TOTAL * 8 + 200;

    logic                               clk;
    logic                               rst_n;
    logic                               in_valid;
    logic                               in_ready;
    logic [31:0]                        in_instr;
    logic [`RV_XLEN-1:0]                in_pc;
    logic                               retire_valid;
    logic                               retire_ready;
    retire_t                            retire;

    logic [31:0]                        lfsr;
    logic [`RV_NREGS-1:0][`RV_XLEN-1:0] shadow;   // architectural state of the model
    retire_t                            exp_q[$];
    logic                               bp_on;
    logic [`RV_XLEN-1:0]                pc_feed;
    int                                 errors;
    int                                 checks;
    int                                 errors_mark;
    int                                 checks_mark;
    int                                 cycles;

    `include "rv_tb_ref.svh"

    rv_exec_core dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_instr     (in_instr),
        .in_pc        (in_pc),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire       (retire)
    );

    always #2 clk = ~clk;

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    // random OP or OP-IMM word on the given registers
    function automatic logic [31:0] alu_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] w;
        f3  = 3'(rand_bits(3));
        alt = rand_bits(1) != 0;
        imm = 12'(rand_bits(12));
        if (f3 == 3'd1 || f3 == 3'd5)
            imm = {1'b0, alt && f3 == 3'd5, 5'd0, imm[4:0]};   // shamt plus sra bit
        if (rand_bits(1) != 0)
            w = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2, rs1, f3, rd, 7'b0110011};
        else
            w = {imm, rs1, f3, rd, 7'b0010011};
        return w;
    endfunction

    function automatic logic [31:0] flow_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [19:0] hi;
        logic [11:0] lo;
        logic [31:0] w;
        rd  = 5'(rand_bits(5));
        rs1 = 5'(rand_bits(5));
        rs2 = (rand_bits(2) == 0) ? rs1 : 5'(rand_bits(5));   // equal operands now and then
        f3  = 3'(rand_bits(3));
        hi  = 20'(rand_bits(20));
        lo  = 12'(rand_bits(12));
        case (3'(rand_bits(3)))
            3'd0, 3'd1: begin
                if (f3[2:1] == 2'b01)
                    f3[2] = 1'b1;   // 010 and 011 are no branches
                w = {lo[11], lo[9:4], rs2, rs1, f3, lo[3:0], lo[10], 7'b1100011};
            end
            3'd2:    w = {hi[19], hi[9:0], hi[10], hi[18:11], rd, 7'b1101111};   // jal
            3'd3:    w = {lo, rs1, 3'd0, rd, 7'b1100111};                        // jalr
            3'd4:    w = {hi, rd, 7'b0110111};
            3'd5:    w = {hi, rd, 7'b0010111};
            default: w = alu_instr(rd, rs1, rs2);
        endcase
        return w;
    endfunction

    function automatic logic [31:0] illegal_word();
        logic [6:0] op;
        case (2'(rand_bits(2)))
            2'd0:    op = 7'b0000011;   // load
            2'd1:    op = 7'b0100011;   // store
            default: begin
                op = 7'(rand_bits(7));
                if (op inside {7'b0010011, 7'b0010111, 7'b0110011, 7'b0110111,
                               7'b1100011, 7'b1100111, 7'b1101111})
                    op = 7'b1111111;
            end
        endcase
        return {25'(rand_bits(25)), op};
    endfunction

    // inputs change only here, on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        retire_ready = bp_on ? (rand_bits(1) != 0) : 1'b1;
    endtask

    task automatic send_instr(input logic [31:0] instr);
        logic accepted;
        in_valid = 1'b1;
        in_instr = instr;
        in_pc    = pc_feed;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = in_ready;
            next_cycle();
        end
        in_valid = 1'b0;
        pc_feed  = pc_feed + 4;
    endtask

    // add x0, xi, x0 shows xi on the retire port without changing state
    task automatic read_regs();
        for (int i = 0; i < `RV_NREGS; i++)
            send_instr({7'd0, 5'd0, 5'(i), 3'd0, 5'd0, 7'b0110011});
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0)
            next_cycle();
        $display("test %s: %0d checks, %0d errors", name, checks - checks_mark,
                 errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    // expected record for every accepted word
    always @(posedge clk) begin
        if (rst_n && in_valid && in_ready)
            exp_q.push_back(ref_retire(in_instr, in_pc, shadow));
    end

    always @(posedge clk) begin
        retire_t want;
        if (rst_n && retire_valid && retire_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("error at %0d ns: retire record with nothing outstanding", $time);
            end else begin
                want = exp_q.pop_front();
                check_val("retire.pc", retire.pc, want.pc);
                check_val("retire.reg_we", 32'(retire.reg_we), 32'(want.reg_we));
                check_val("retire.illegal", 32'(retire.illegal), 32'(want.illegal));
                if (want.reg_we) begin
                    check_val("retire.rd", 32'(retire.rd), 32'(want.rd));
                    check_val("retire.result", retire.result, want.result);
                end
                if (!want.illegal)
                    check_val("retire.next_pc", retire.next_pc, want.next_pc);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("error: tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("sim failed");
        $finish;
    end

    initial begin
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] last_rd;
        logic [4:0] prev_rd;
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_instr     = '0;
        in_pc        = '0;
        retire_ready = 1'b1;
        lfsr         = 32'h1d07e0a3;
        shadow       = '0;
        bp_on        = 1'b0;
        pc_feed      = 32'h0000_1000;
        errors       = 0;
        checks       = 0;
        errors_mark  = 0;
        checks_mark  = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_val("retire_valid", 32'(retire_valid), 32'd0);
        check_val("in_ready", 32'(in_ready), 32'd1);
        for (int i = 1; i < `RV_NREGS; i++)
            send_instr({12'd0, 5'd0, 3'd0, 5'(i), 7'b0010011});   // addi xi, x0, 0
        send_instr({12'h5a5, 5'd0, 3'd0, 5'd0, 7'b0010011});
        send_instr({20'hfffff, 5'd0, 7'b0110111});
        send_instr({20'h12345, 5'd0, 7'b0010111});
        read_regs();
        end_test("reset");

        // seed every register with a random upper value, sign bits included
        for (int i = 1; i < `RV_NREGS; i++)
            send_instr({20'(rand_bits(20)), 5'(i), 7'b0110111});
        for (int i = 0; i < N_ALU; i++) begin
            rd  = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            send_instr(alu_instr(rd, rs1, rs2));
        end
        end_test("alu");

        last_rd = 5'd1;
        prev_rd = 5'd2;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd = 5'(rand_bits(5));
            if (rd == 5'd0)
                rd = 5'd3;
            rs1     = (rand_bits(1) != 0) ? last_rd : prev_rd;
            rs2     = (rand_bits(1) != 0) ? last_rd : prev_rd;
            send_instr(alu_instr(rd, rs1, rs2));
            prev_rd = last_rd;
            last_rd = rd;
        end
        end_test("chain");

        for (int i = 0; i < N_FLOW; i++)
            send_instr(flow_instr());
        end_test("control");

        bp_on = 1'b1;
        for (int i = 0; i < N_BP; i++) begin
            if (rand_bits(1) != 0) begin
                send_instr(flow_instr());
            end else begin
                rd  = 5'(rand_bits(5));
                rs1 = 5'(rand_bits(5));
                rs2 = 5'(rand_bits(5));
                send_instr(alu_instr(rd, rs1, rs2));
            end
        end
        end_test("backpressure");
        bp_on = 1'b0;

        for (int i = 0; i < N_ILL; i++)
            send_instr(illegal_word());
        read_regs();   // state must match the untouched model
        end_test("illegal");

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- rv_exec_core.f
+incdir+include
design/rv_isa_pkg.sv
design/rv_pipe_pkg.sv
design/rv_controller.sv
design/rv_regfile.sv
design/rv_pipe_reg.sv
design/rv_decode_stage.sv
design/rv_execute_stage.sv
design/rv_exec_core.sv
bench/rv_exec_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= rv_exec_core_tb
FILELIST  ?= rv_exec_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "FAIL: run ended early"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
